// File: Bender.yml
package:
  name: fp_adder

sources:
  - files:
      - src/fp_add_pkg.sv
      - src/fp_stage_if.sv
      - src/fp_align.sv
      - src/fp_mant_add.sv
      - src/fp_round_pack.sv
      - src/fp_result_queue.sv
      - src/fp_adder_top.sv
  - target: test
    files:
      - tb/tb_clock.sv
      - tb/fp_adder_tb.sv

// File: sim.f
src/fp_add_pkg.sv
src/fp_stage_if.sv
src/fp_align.sv
src/fp_mant_add.sv
src/fp_round_pack.sv
src/fp_result_queue.sv
src/fp_adder_top.sv
tb/tb_clock.sv
tb/fp_adder_tb.sv

// File: src/fp_add_pkg.sv
// binary32 field widths, vector types, rounding-mode/op/special enums, constants, credit depths
package fp_add_pkg;

   // binary32 field widths
   localparam int W_WORD = 32;
   localparam int W_EXP  = 8;
   localparam int W_FRAC = 23;
   // hidden bit + fraction + guard, round, sticky
   localparam int W_SIG  = W_FRAC + 4;
   // significand plus carry-out
   localparam int W_SUM  = W_SIG + 1;

   typedef logic [W_WORD-1:0]        fp_word_t;
   typedef logic [W_EXP-1:0]         exp_t;
   typedef logic [W_FRAC-1:0]        frac_t;
   typedef logic [W_SIG-1:0]         sig_t;
   typedef logic [W_SUM-1:0]         sum_t;
   // exponent with room for the carry and for negative values after normalization
   typedef logic signed [W_EXP+1:0]  exp_ext_t;

   // flag vector is {invalid, overflow, underflow, inexact}
   typedef logic [3:0] fp_flags_t;
   localparam int FLAG_NV = 3;
   localparam int FLAG_OF = 2;
   localparam int FLAG_UF = 1;
   localparam int FLAG_NX = 0;

   // codes 5..7 behave as RNE
   typedef enum logic [2:0] {
      RNE = 3'd0,
      RTZ = 3'd1,
      RDN = 3'd2,
      RUP = 3'd3,
      RMM = 3'd4
   } round_mode_e;

   typedef enum logic {
      OP_ADD = 1'b0,
      OP_SUB = 1'b1
   } fp_op_e;

   // special-case class, resolved in stage one and applied in stage three
   typedef enum logic [1:0] {
      SP_NONE    = 2'd0,
      SP_INF     = 2'd1,
      SP_NAN     = 2'd2,
      SP_INVALID = 2'd3
   } special_e;

   localparam int       BIAS    = 127;
   localparam exp_t     EXP_MAX = exp_t'(2 * BIAS + 1);
   localparam fp_word_t QNAN    = 32'h7FC0_0000;

   // credit depths; IN_CREDITS is also the result queue depth
   localparam int IN_CREDITS  = 4;
   localparam int OUT_CREDITS = 2;
   localparam int QPTR_W      = $clog2(IN_CREDITS);
   localparam int QCNT_W      = $clog2(IN_CREDITS + 1);
   localparam int OCRED_W     = $clog2(OUT_CREDITS + 1);

   typedef logic [QPTR_W-1:0]  qptr_t;
   typedef logic [QCNT_W-1:0]  qcnt_t;
   typedef logic [OCRED_W-1:0] ocred_t;

endpackage

// File: src/fp_adder_top.sv
// fp_adder_top: three-stage binary32 add/sub pipeline with credit-based result queue
`timescale 1ns/1ps

module fp_adder_top (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    in_valid,
   input  fp_add_pkg::fp_word_t    a,
   input  fp_add_pkg::fp_word_t    b,
   input  fp_add_pkg::fp_op_e      op,
   input  fp_add_pkg::round_mode_e rm,
   output logic                    in_credit,
   output logic                    out_valid,
   output fp_add_pkg::fp_word_t    result,
   output fp_add_pkg::fp_flags_t   flags,
   input  logic                    out_credit
);
   import fp_add_pkg::*;

   // align to add, add to round
   fp_stage_if align_if ();
   fp_stage_if sum_if ();

   logic      pack_valid;
   fp_word_t  pack_result;
   fp_flags_t pack_flags;

   fp_align u_align (
      .clk      (clk),
      .rst      (rst),
      .in_valid (in_valid),
      .a        (a),
      .b        (b),
      .op       (op),
      .rm       (rm),
      .out      (align_if.src)
   );

   fp_mant_add u_mant_add (
      .clk (clk),
      .rst (rst),
      .in  (align_if.dst),
      .out (sum_if.src)
   );

   fp_round_pack u_round_pack (
      .clk    (clk),
      .rst    (rst),
      .in     (sum_if.dst),
      .valid  (pack_valid),
      .result (pack_result),
      .flags  (pack_flags)
   );

   fp_result_queue u_queue (
      .clk        (clk),
      .rst        (rst),
      .wr_valid   (pack_valid),
      .wr_result  (pack_result),
      .wr_flags   (pack_flags),
      .out_credit (out_credit),
      .out_valid  (out_valid),
      .result     (result),
      .flags      (flags),
      .in_credit  (in_credit)
   );

endmodule

// File: src/fp_align.sv
// fp_align: operand unpack, classification, magnitude swap and sticky right shift
`timescale 1ns/1ps

module fp_align (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    in_valid,
   input  fp_add_pkg::fp_word_t    a,
   input  fp_add_pkg::fp_word_t    b,
   input  fp_add_pkg::fp_op_e      op,
   input  fp_add_pkg::round_mode_e rm,
   fp_stage_if.src                 out
);
   import fp_add_pkg::*;

   logic                sign_a;
   logic                sign_b;
   exp_t                exp_a;
   exp_t                exp_b;
   frac_t               frac_a;
   frac_t               frac_b;
   logic                zero_a;
   logic                zero_b;
   logic                inf_a;
   logic                inf_b;
   logic                nan_a;
   logic                nan_b;
   logic                eff_sub;
   logic                swap;
   logic [W_WORD-2:0]   mag_a;
   logic [W_WORD-2:0]   mag_b;
   sig_t                sig_a;
   sig_t                sig_b;
   sig_t                sig_l;
   sig_t                sig_s;
   exp_t                exp_l;
   exp_t                diff;
   logic [4:0]          shamt;
   logic [2*W_SIG-1:0]  wide;
   sig_t                sig_al;
   special_e            special;
   logic                sp_sign;

   assign {sign_a, exp_a, frac_a} = a;
   assign exp_b  = b[W_WORD-2 -: W_EXP];
   assign frac_b = b[W_FRAC-1:0];
   // subtraction is folded into the sign of b
   assign sign_b  = b[W_WORD-1] ^ (op == OP_SUB);
   assign eff_sub = sign_a ^ sign_b;

   // subnormals count as zero
   assign zero_a = (exp_a == '0);
   assign zero_b = (exp_b == '0);
   assign inf_a  = (exp_a == EXP_MAX) && (frac_a == '0);
   assign inf_b  = (exp_b == EXP_MAX) && (frac_b == '0);
   assign nan_a  = (exp_a == EXP_MAX) && (frac_a != '0);
   assign nan_b  = (exp_b == EXP_MAX) && (frac_b != '0);

   assign mag_a = zero_a ? '0 : {exp_a, frac_a};
   assign mag_b = zero_b ? '0 : {exp_b, frac_b};
   assign sig_a = zero_a ? '0 : {1'b1, frac_a, 3'b000};
   assign sig_b = zero_b ? '0 : {1'b1, frac_b, 3'b000};
   assign swap  = (mag_b > mag_a);

   assign sig_l = swap ? sig_b : sig_a;
   assign sig_s = swap ? sig_a : sig_b;
   assign exp_l = swap ? exp_b : exp_a;
   assign diff  = swap ? (exp_b - exp_a) : (exp_a - exp_b);

   // shifts of W_SIG or more leave only the sticky bit
   assign shamt  = (diff > exp_t'(W_SIG)) ? 5'(W_SIG) : diff[4:0];
   assign wide   = {sig_s, {W_SIG{1'b0}}} >> shamt;
   assign sig_al = {wide[2*W_SIG-1:W_SIG+1], |wide[W_SIG:0]};

   always_comb begin
      special = SP_NONE;
      sp_sign = 1'b0;
      if (nan_a || nan_b) begin
         special = SP_NAN;
         // quiet bit clear marks a signaling NaN
         sp_sign = (nan_a && !frac_a[W_FRAC-1]) || (nan_b && !frac_b[W_FRAC-1]);
      end else if (inf_a && inf_b && eff_sub) begin
         special = SP_INVALID;
      end else if (inf_a) begin
         special = SP_INF;
         sp_sign = sign_a;
      end else if (inf_b) begin
         special = SP_INF;
         sp_sign = sign_b;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         out.valid <= 1'b0;
      end else begin
         out.valid <= in_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in_valid) begin
         out.sign         <= swap ? sign_b : sign_a;
         out.exp          <= exp_l;
         out.sig          <= {1'b0, sig_l};
         out.sig_b        <= sig_al;
         out.eff_sub      <= eff_sub;
         out.mode         <= rm;
         out.special      <= special;
         out.special_sign <= sp_sign;
         out.zero_result  <= 1'b0;
      end
   end

endmodule

// File: src/fp_mant_add.sv
// fp_mant_add: significand add/subtract with carry-out and exact-cancellation detect
`timescale 1ns/1ps

module fp_mant_add (
   input  logic    clk,
   input  logic    rst,
   fp_stage_if.dst in,
   fp_stage_if.src out
);
   import fp_add_pkg::*;

   sum_t sum;
   logic cancel;
   logic sum_sign;

   // larger magnitude comes first, so the difference never goes negative
   assign sum = in.eff_sub ? (in.sig - sum_t'(in.sig_b)) : (in.sig + sum_t'(in.sig_b));
   assign cancel = (sum == '0);

   // exact cancellation is +0, or -0 when rounding down
   // a zero from two like-signed zeros keeps their sign
   assign sum_sign = (cancel && in.eff_sub) ? (in.mode == RDN) : in.sign;

   always_ff @(posedge clk) begin
      if (rst) begin
         out.valid <= 1'b0;
      end else begin
         out.valid <= in.valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in.valid) begin
         out.sign         <= sum_sign;
         out.exp          <= in.exp;
         out.sig          <= sum;
         out.sig_b        <= '0;
         out.eff_sub      <= in.eff_sub;
         out.mode         <= in.mode;
         out.special      <= in.special;
         out.special_sign <= in.special_sign;
         out.zero_result  <= cancel;
      end
   end

endmodule

// File: src/fp_result_queue.sv
// fp_result_queue: result FIFO with upstream credit return and downstream credit counter
`timescale 1ns/1ps

module fp_result_queue (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  wr_valid,
   input  fp_add_pkg::fp_word_t  wr_result,
   input  fp_add_pkg::fp_flags_t wr_flags,
   input  logic                  out_credit,
   output logic                  out_valid,
   output fp_add_pkg::fp_word_t  result,
   output fp_add_pkg::fp_flags_t flags,
   output logic                  in_credit
);
   import fp_add_pkg::*;

   fp_word_t  res_mem [IN_CREDITS];
   fp_flags_t flg_mem [IN_CREDITS];
   qptr_t     wr_ptr;
   qptr_t     rd_ptr;
   qcnt_t     count;
   ocred_t    credits;
   logic      pop;

   function automatic qptr_t next_ptr(input qptr_t p);
      return (p == qptr_t'(IN_CREDITS - 1)) ? qptr_t'(0) : qptr_t'(p + 1'b1);
   endfunction

   // one entry leaves per cycle while a downstream credit is held
   assign pop       = (count != '0) && (credits != '0);
   assign out_valid = pop;
   // the freed slot goes straight back upstream as a credit
   assign in_credit = pop;
   assign result    = res_mem[rd_ptr];
   assign flags     = flg_mem[rd_ptr];

   always_ff @(posedge clk) begin
      if (wr_valid) begin
         res_mem[wr_ptr] <= wr_result;
         flg_mem[wr_ptr] <= wr_flags;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         count   <= '0;
         credits <= ocred_t'(OUT_CREDITS);
      end else begin
         if (wr_valid) begin
            wr_ptr <= next_ptr(wr_ptr);
         end
         if (pop) begin
            rd_ptr <= next_ptr(rd_ptr);
         end
         count   <= count + qcnt_t'(wr_valid) - qcnt_t'(pop);
         // a return in the same cycle as a spend nets out
         credits <= credits + ocred_t'(out_credit) - ocred_t'(pop);
      end
   end

endmodule

// File: src/fp_round_pack.sv
// fp_round_pack: normalize, round per mode, overflow/underflow, special overrides, flags
`timescale 1ns/1ps

module fp_round_pack (
   input  logic                  clk,
   input  logic                  rst,
   fp_stage_if.dst               in,
   output logic                  valid,
   output fp_add_pkg::fp_word_t  result,
   output fp_add_pkg::fp_flags_t flags
);
   import fp_add_pkg::*;

   logic [4:0]         lz;
   sig_t               norm;
   exp_ext_t           exp_n;
   exp_ext_t           exp_r;
   logic               lost;
   logic               rnd_up;
   logic               ovf_to_inf;
   logic [W_FRAC+1:0]  mant_r;
   fp_word_t           res_c;
   fp_flags_t          flg_c;

   // leading zeros of the significand field, carry bit excluded
   function automatic logic [4:0] count_lz(input sig_t v);
      logic [4:0] n;
      logic       hit;
      n   = '0;
      hit = 1'b0;
      for (int i = W_SIG - 1; i >= 0; i--) begin
         if (!hit && v[i]) begin
            n   = 5'(W_SIG - 1 - i);
            hit = 1'b1;
         end
      end
      return n;
   endfunction

   always_comb begin
      lz = count_lz(in.sig[W_SIG-1:0]);
      if (in.sig[W_SUM-1]) begin
         // carry out, one place right with the dropped bit kept in sticky
         norm  = {in.sig[W_SUM-1:2], in.sig[1] | in.sig[0]};
         exp_n = exp_ext_t'(in.exp) + exp_ext_t'(1);
      end else begin
         norm  = in.sig[W_SIG-1:0] << lz;
         exp_n = exp_ext_t'(in.exp) - exp_ext_t'(lz);
      end
   end

   // guard, round and sticky sit in norm[2:0]
   assign lost = |norm[2:0];

   always_comb begin
      case (in.mode)
         RTZ: rnd_up = 1'b0;
         RDN: rnd_up = in.sign & lost;
         RUP: rnd_up = ~in.sign & lost;
         RMM: rnd_up = norm[2];
         // RNE and the unused codes
         default: rnd_up = norm[2] & (norm[1] | norm[0] | norm[3]);
      endcase
   end

   always_comb begin
      case (in.mode)
         RTZ: ovf_to_inf = 1'b0;
         RDN: ovf_to_inf = in.sign;
         RUP: ovf_to_inf = ~in.sign;
         default: ovf_to_inf = 1'b1;
      endcase
   end

   // a rounding carry leaves the fraction all zero and bumps the exponent
   assign mant_r = {1'b0, norm[W_SIG-1:3]} + (W_FRAC + 2)'(rnd_up);
   assign exp_r  = exp_n + exp_ext_t'(mant_r[W_FRAC+1]);

   always_comb begin
      res_c          = {in.sign, exp_r[W_EXP-1:0], mant_r[W_FRAC-1:0]};
      flg_c          = '0;
      flg_c[FLAG_NX] = lost;
      if (in.zero_result) begin
         res_c = {in.sign, {(W_WORD-1){1'b0}}};
         flg_c = '0;
      end else if (exp_n < exp_ext_t'(1)) begin
         // below the normal range, flush to signed zero
         res_c          = {in.sign, {(W_WORD-1){1'b0}}};
         flg_c[FLAG_UF] = 1'b1;
         flg_c[FLAG_NX] = 1'b1;
      end else if (exp_r >= exp_ext_t'(EXP_MAX)) begin
         flg_c[FLAG_OF] = 1'b1;
         flg_c[FLAG_NX] = 1'b1;
         if (ovf_to_inf) begin
            res_c = {in.sign, EXP_MAX, {W_FRAC{1'b0}}};
         end else begin
            res_c = {in.sign, exp_t'(EXP_MAX - 1'b1), {W_FRAC{1'b1}}};
         end
      end

      // special classes win over the datapath result
      case (in.special)
         SP_NAN: begin
            res_c          = QNAN;
            flg_c          = '0;
            flg_c[FLAG_NV] = in.special_sign;
         end
         SP_INVALID: begin
            res_c          = QNAN;
            flg_c          = '0;
            flg_c[FLAG_NV] = 1'b1;
         end
         SP_INF: begin
            res_c = {in.special_sign, EXP_MAX, {W_FRAC{1'b0}}};
            flg_c = '0;
         end
         default: begin
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         valid <= 1'b0;
      end else begin
         valid <= in.valid;
      end
   end

   always_ff @(posedge clk) begin
      if (in.valid) begin
         result <= res_c;
         flags  <= flg_c;
      end
   end

endmodule

// File: src/fp_stage_if.sv
// pipeline stage link carrying aligned operands or the raw sum, with src and dst modports
`timescale 1ns/1ps

interface fp_stage_if;
   import fp_add_pkg::*;

   logic        valid;
   logic        sign;
   exp_t        exp;
   // larger significand on the first link, raw sum with carry on the second
   sum_t        sig;
   // aligned smaller significand, first link only
   sig_t        sig_b;
   logic        eff_sub;
   round_mode_e mode;
   special_e    special;
   // infinity sign for SP_INF, signaling-NaN seen for SP_NAN
   logic        special_sign;
   logic        zero_result;

   modport src (
      output valid, sign, exp, sig, sig_b, eff_sub, mode, special, special_sign, zero_result
   );

   modport dst (
      input valid, sign, exp, sig, sig_b, eff_sub, mode, special, special_sign, zero_result
   );

endinterface

// File: tb/fp_adder_tb.sv
// LFSR stimulus, credit driver and consumer, reference model, checks, watchdog
`timescale 1ns/1ps

module fp_adder_tb;
   import fp_add_pkg::*;

   localparam int N_NORMAL  = 200;
   localparam int N_LIMITS  = 100;
   localparam int N_SPECIAL = 100;
   localparam int N_CANCEL  = 40;
   localparam int N_CREDIT  = 60;
   localparam int TOTAL_OPS = N_NORMAL + N_LIMITS + N_SPECIAL + N_CANCEL + N_CREDIT;

   logic        clk;
   logic        rst;
   logic        in_valid;
   fp_word_t    a;
   fp_word_t    b;
   fp_op_e      op;
   round_mode_e rm;
   logic        in_credit;
   logic        out_valid;
   fp_word_t    result;
   fp_flags_t   flags;
   logic        out_credit;

   logic [31:0] lfsr = 32'h8281;
   // expected {flags, result} and the test id of every operation in flight
   logic [35:0] exp_q[$];
   int          id_q[$];
   int          gap_q[$];
   int          up_credits = IN_CREDITS;
   int          dn_credits = OUT_CREDITS;
   int          returns_left = 0;
   logic        slow_consumer = 1'b0;

   tb_clock u_clock (
      .clk (clk)
   );

   fp_adder_top uut (
      .clk        (clk),
      .rst        (rst),
      .in_valid   (in_valid),
      .a          (a),
      .b          (b),
      .op         (op),
      .rm         (rm),
      .in_credit  (in_credit),
      .out_valid  (out_valid),
      .result     (result),
      .flags      (flags),
      .out_credit (out_credit)
   );

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Simulation FAILED");
      $fatal(1, "run stopped at the first error");
   endtask

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr_next(lfsr);
         v = {v[30:0], lfsr[0]};
      end
      return v;
   endfunction

   function automatic string test_name(input int id);
      case (id)
         1: return "normal_add_sub";
         2: return "overflow_underflow";
         3: return "special_values";
         4: return "cancellation";
         default: return "credit_protocol";
      endcase
   endfunction

   function automatic int clamp_exp(input int e);
      if (e < 1) return 1;
      if (e > 254) return 254;
      return e;
   endfunction

   function automatic fp_word_t make_word(input int e);
      return {1'(rand_bits(1)), 8'(e), 23'(rand_bits(23))};
   endfunction

   // exact sum on a 128-bit significand frame giving {flags, word}
   function automatic logic [35:0] expected_sum(input fp_word_t x, input fp_word_t y,
                                                input fp_op_e o, input round_mode_e m);
      logic         sx;
      logic         sy;
      logic         sl;
      logic         snan;
      logic         eff_sub;
      logic         inc;
      logic         to_inf;
      logic [7:0]   ex;
      logic [7:0]   ey;
      logic [22:0]  fx;
      logic [22:0]  fy;
      logic [23:0]  ml;
      logic [23:0]  ms;
      logic [24:0]  mant;
      logic [127:0] wl;
      logic [127:0] ws;
      logic [127:0] mag;
      logic [127:0] rem;
      logic [127:0] half;
      int           el;
      int           es;
      int           d;
      int           p;
      int           e;
      sx = x[31];
      ex = x[30:23];
      fx = x[22:0];
      sy = y[31] ^ (o == OP_SUB);
      ey = y[30:23];
      fy = y[22:0];
      snan = (ex == 8'hFF && fx != 0 && !fx[22]) || (ey == 8'hFF && fy != 0 && !fy[22]);
      if ((ex == 8'hFF && fx != 0) || (ey == 8'hFF && fy != 0)) return {snan, 3'b000, QNAN};
      if (ex == 8'hFF && ey == 8'hFF && sx != sy) return {4'b1000, QNAN};
      if (ex == 8'hFF) return {4'b0000, sx, 8'hFF, 23'd0};
      if (ey == 8'hFF) return {4'b0000, sy, 8'hFF, 23'd0};
      // subnormals enter as zero
      if ((ex == 0 ? 31'd0 : x[30:0]) >= (ey == 0 ? 31'd0 : y[30:0])) begin
         sl = sx;
         el = int'(ex);
         es = int'(ey);
         ml = (ex == 0) ? 24'd0 : {1'b1, fx};
         ms = (ey == 0) ? 24'd0 : {1'b1, fy};
      end else begin
         sl = sy;
         el = int'(ey);
         es = int'(ex);
         ml = {1'b1, fy};
         ms = (ex == 0) ? 24'd0 : {1'b1, fx};
      end
      eff_sub = sx ^ sy;
      d = el - es;
      wl = 128'(ml) << 100;
      // an operand this far below only tells the rounding which side it is on
      if (ms == 0) ws = '0;
      else if (d > 100) ws = 128'd1;
      else ws = (128'(ms) << 100) >> d;
      mag = eff_sub ? (wl - ws) : (wl + ws);
      if (mag == 0) return {4'b0000, (eff_sub ? (m == RDN) : sl), 31'd0};
      p = 127;
      while (!mag[p]) p--;
      e = p + el - 123;
      if (e < 1) return {4'b0011, sl, 31'd0};
      mant = 25'(mag >> (p - 23));
      rem  = mag & ((128'd1 << (p - 23)) - 128'd1);
      half = 128'd1 << (p - 24);
      case (m)
         RTZ: inc = 1'b0;
         RDN: inc = sl && (rem != 0);
         RUP: inc = !sl && (rem != 0);
         RMM: inc = (rem >= half);
         default: inc = (rem > half) || (rem == half && mant[0]);
      endcase
      mant = mant + 25'(inc);
      if (mant[24]) begin
         mant = mant >> 1;
         e++;
      end
      if (e >= 255) begin
         case (m)
            RTZ: to_inf = 1'b0;
            RDN: to_inf = sl;
            RUP: to_inf = !sl;
            default: to_inf = 1'b1;
         endcase
         if (to_inf) return {4'b0101, sl, 8'hFF, 23'd0};
         return {4'b0101, sl, 8'hFE, 23'h7FFFFF};
      end
      return {3'b000, (rem != 0), sl, 8'(e), mant[22:0]};
   endfunction

   // one beat only while an upstream credit is held
   task automatic issue(input int tid, input fp_word_t x, input fp_word_t y,
                        input fp_op_e o, input round_mode_e m);
      int gap;
      gap = int'(rand_bits(2));
      repeat (gap) @(negedge clk);
      while (up_credits == 0) @(negedge clk);
      a = x;
      b = y;
      op = o;
      rm = m;
      in_valid = 1'b1;
      up_credits--;
      exp_q.push_back(expected_sum(x, y, o, m));
      id_q.push_back(tid);
      @(negedge clk);
      in_valid = 1'b0;
   endtask

   function automatic round_mode_e any_mode();
      return round_mode_e'(3'(rand_bits(3)));
   endfunction

   task automatic run_normal(input int tid, input int count);
      int ea;
      int eb;
      for (int i = 0; i < count; i++) begin
         ea = clamp_exp(int'(rand_bits(8)));
         if (rand_bits(1)) eb = clamp_exp(ea + int'(rand_bits(5)) - 16);
         else eb = clamp_exp(int'(rand_bits(8)));
         issue(tid, make_word(ea), make_word(eb), fp_op_e'(1'(rand_bits(1))), any_mode());
      end
   endtask

   function automatic int edge_exp();
      if (rand_bits(1)) return 251 + int'(rand_bits(2));
      return 1 + int'(rand_bits(2));
   endfunction

   task automatic run_limits();
      int ea;
      for (int i = 0; i < N_LIMITS; i++) begin
         ea = edge_exp();
         issue(2, make_word(ea), make_word(ea < 128 ? 1 + int'(rand_bits(2)) : edge_exp()),
               fp_op_e'(1'(rand_bits(1))), any_mode());
      end
   endtask

   function automatic fp_word_t special_word();
      logic [2:0] kind;
      fp_word_t   w;
      kind = 3'(rand_bits(3));
      w = make_word(clamp_exp(int'(rand_bits(8))));
      case (kind)
         3'd0: w[30:0] = {8'hFF, 23'd0};
         3'd1: w[30:0] = {8'hFF, 1'b1, 22'(rand_bits(22))};
         // signaling NaN needs a nonzero payload
         3'd2: w[30:0] = {8'hFF, 1'b0, 22'(rand_bits(21)) | 22'd1};
         3'd3: w[30:0] = '0;
         3'd4: w[30:0] = {8'h00, 23'(rand_bits(23)) | 23'd1};
         default: begin
         end
      endcase
      return w;
   endfunction

   task automatic run_cancel();
      fp_word_t w;
      for (int i = 0; i < N_CANCEL; i++) begin
         w = make_word(clamp_exp(int'(rand_bits(8))));
         if (rand_bits(1)) issue(4, w, w, OP_SUB, any_mode());
         else issue(4, w, w ^ 32'h8000_0000, OP_ADD, any_mode());
      end
   endtask

   // result and credit monitor sampled on the rising edge
   always @(posedge clk) begin : monitor
      logic [35:0] want;
      int          tid;
      if (rst === 1'b0) begin
         assert (in_credit === out_valid)
            else abort_run("in_credit pulse does not line up with a retired result");
         if (out_valid === 1'b1) begin
            assert (dn_credits > 0) else abort_run("out_valid raised with no downstream credit");
            assert (exp_q.size() > 0) else abort_run("result arrived with no operation in flight");
            want = exp_q.pop_front();
            tid = id_q.pop_front();
            assert ({flags, result} === want)
               else abort_run($sformatf("MISMATCH %s: expected %h flags %b, actual %h flags %b",
                                        test_name(tid), want[31:0], want[35:32], result, flags));
            gap_q.push_back(slow_consumer ? 16 + int'(rand_bits(6)) : int'(rand_bits(2)));
            returns_left++;
            dn_credits--;
         end
         if (in_credit === 1'b1) begin
            up_credits++;
         end
         if (out_credit === 1'b1) dn_credits++;
      end
   end

   // consumer returns one credit per result after a random delay
   initial begin : consumer
      int gap;
      out_credit = 1'b0;
      wait (rst === 1'b0);
      forever begin
         @(negedge clk);
         out_credit = 1'b0;
         if (gap_q.size() > 0) begin
            gap = gap_q.pop_front();
            repeat (gap) @(negedge clk);
            out_credit = 1'b1;
            returns_left--;
         end
      end
   end

   initial begin : watchdog
      repeat (TOTAL_OPS * 200) @(posedge clk);
      abort_run("timeout: results did not drain in the allowed number of cycles");
   end

   initial begin : driver
      rst = 1'b1;
      in_valid = 1'b0;
      a = '0;
      b = '0;
      op = OP_ADD;
      rm = RNE;
      repeat (3) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      run_normal(1, N_NORMAL);
      run_limits();
      for (int i = 0; i < N_SPECIAL; i++) begin
         issue(3, special_word(), special_word(), fp_op_e'(1'(rand_bits(1))), any_mode());
      end
      run_cancel();
      // long credit droughts downstream
      slow_consumer = 1'b1;
      run_normal(5, N_CREDIT);
      while (exp_q.size() != 0 || returns_left != 0) @(negedge clk);
      repeat (2) @(negedge clk);
      $display("Simulation PASSED");
      $finish;
   end

endmodule

// File: tb/tb_clock.sv
// tb_clock: free-running testbench clock, 4 ns period
`timescale 1ns/1ps

module tb_clock (
   output logic clk
);

   localparam real HALF_PERIOD = 2.0;

   initial begin
      clk = 1'b0;
      forever #(HALF_PERIOD) clk = ~clk;
   end

endmodule
